// File: verilog/mem_msg_pkg.sv
/* Message formats shared by the cache port and the memory port.
   Memory messages carry a whole 16-byte line; cache messages carry one word. */
`default_nettype none

package mem_msg_pkg;

  localparam int OPAQUE_BITS = 8;
  localparam int ADDR_BITS   = 32;
  localparam int WORD_BITS   = 32;
  localparam int LINE_BITS   = 128;

  typedef enum logic [1:0] {
    MEM_READ       = 2'd0,
    MEM_WRITE      = 2'd1,
    MEM_WRITE_INIT = 2'd2
  } mem_op_e;

  // Word-wide request and response at the cache port
  typedef struct packed {
    mem_op_e                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [ADDR_BITS-1:0]   addr;
    logic [WORD_BITS-1:0]   data;
  } cache_req_t;

  typedef struct packed {
    mem_op_e                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [WORD_BITS-1:0]   data;
  } cache_resp_t;

  // Line-wide request and response at the memory port
  typedef struct packed {
    mem_op_e                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [ADDR_BITS-1:0]   addr;
    logic [LINE_BITS-1:0]   data;
  } mem_req_t;

  typedef struct packed {
    mem_op_e                op;
    logic [OPAQUE_BITS-1:0] opaque;
    logic [LINE_BITS-1:0]   data;
  } mem_resp_t;

endpackage

`default_nettype wire

// File: verilog/cache_pkg.sv
/* Geometry of the 256-byte two-way cache and the internal command formats.
   Changing the geometry needs matching address field widths below. */
`default_nettype none

package cache_pkg;

  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 8;
  localparam int OFFSET_BITS    = 4;
  localparam int IDX_BITS       = 3;
  localparam int TAG_BITS       = 25;
  localparam int WORDS_PER_LINE = 4;

  // Address fields: tag [31:7], index [6:4], word [3:2]
  typedef logic [IDX_BITS-1:0] cache_idx_t;
  typedef logic [TAG_BITS-1:0] cache_tag_t;
  typedef logic [1:0]          word_sel_t;

  // Metadata update for the selected set and way
  typedef struct packed {
    logic valid_wen;
    logic valid_val;
    logic dirty_wen;
    logic dirty_val;
    logic lru_wen;
  } meta_cmd_t;

  // Controller to datapath enables
  typedef struct packed {
    logic                 req_en;
    logic                 memresp_en;
    logic                 refill;
    logic                 tag_wen;
    logic                 data_wen;
    logic                 read_en;
    logic                 evict_en;
    mem_msg_pkg::mem_op_e memreq_op;
    logic                 way;
  } dpath_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/cache_meta.sv
/* Valid, dirty and LRU state for all sets; reads are combinational from idx.
   A write lands in the set at idx and, for valid and dirty, in the given way. */
`default_nettype none
`timescale 1ns/1ns

module cache_meta (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::cache_idx_t  idx,
  input  logic                   way,
  input  cache_pkg::meta_cmd_t   cmd,
  output logic [1:0]             valid,
  output logic [1:0]             dirty,
  output logic                   lru_way
);

  logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] valid_q;
  logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] dirty_q;
  logic [cache_pkg::NUM_SETS-1:0]                          lru_q;

  // ------------------------------------------------------------
  // Bit arrays
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (cmd.valid_wen) begin
        valid_q[idx][way] <= cmd.valid_val;
      end
      if (cmd.dirty_wen) begin
        dirty_q[idx][way] <= cmd.dirty_val;
      end
    end
  end

  // LRU points at the way not just touched
  always_ff @(posedge clk) begin
    if (reset) begin
      lru_q <= '0;
    end else if (cmd.lru_wen) begin
      lru_q[idx] <= ~way;
    end
  end

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------

  assign valid   = valid_q[idx];
  assign dirty   = dirty_q[idx];
  assign lru_way = lru_q[idx];

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
/* Blocking cache FSM: one request in flight, write-back with LRU victim.
   The way is chosen in tag check and held until the response is taken. */
`default_nettype none
`timescale 1ns/1ns

module cache_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cachereq_val,
  output logic                     cachereq_rdy,
  output logic                     cacheresp_val,
  input  logic                     cacheresp_rdy,
  output logic                     memreq_val,
  input  logic                     memreq_rdy,
  input  logic                     memresp_val,
  output logic                     memresp_rdy,
  input  mem_msg_pkg::mem_op_e     req_op,
  input  cache_pkg::cache_idx_t    req_idx,
  input  logic [1:0]               tag_match,
  output cache_pkg::dpath_ctrl_t   ctrl
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_TAG_CHECK,
    ST_READ_ACCESS,
    ST_WRITE_ACCESS,
    ST_INIT_ACCESS,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_REFILL_UPDATE,
    ST_EVICT_PREP,
    ST_EVICT_REQ,
    ST_EVICT_WAIT,
    ST_WAIT
  } state_e;

  // One row of the control table
  typedef struct packed {
    logic req_rdy;
    logic resp_val;
    logic mreq_val;
    logic mresp_rdy;
    logic req_en;
    logic mresp_en;
    logic refill;
    logic tag_wen;
    logic data_wen;
    logic read_en;
    logic evict_en;
    logic valid_wen;
    logic valid_val;
    logic dirty_wen;
    logic dirty_val;
    logic lru_wen;
    logic way_en;
  } ctrl_row_t;

  state_e               state_q;
  state_e               state_d;
  ctrl_row_t            row;
  cache_pkg::meta_cmd_t meta_cmd;
  logic [1:0]           valid;
  logic [1:0]           dirty;
  logic                 lru_way;
  logic [1:0]           hit_vec;
  logic                 hit;
  logic                 evict;
  logic                 refill;
  logic                 way_q;
  logic                 is_read;
  logic                 is_init;

  cache_meta u_meta (
    .clk     (clk),
    .reset   (reset),
    .idx     (req_idx),
    .way     (way_q),
    .cmd     (meta_cmd),
    .valid   (valid),
    .dirty   (dirty),
    .lru_way (lru_way)
  );

  // ------------------------------------------------------------
  // Hit and miss decisions
  // ------------------------------------------------------------

  assign hit_vec = tag_match & valid;
  assign hit     = |hit_vec;
  assign evict   = !hit && valid[lru_way] && dirty[lru_way];
  assign refill  = !hit && !evict;
  assign is_read = (req_op == mem_msg_pkg::MEM_READ);
  assign is_init = (req_op == mem_msg_pkg::MEM_WRITE_INIT);

  // Hit way, or the LRU victim on a miss
  always_ff @(posedge clk) begin
    if (reset) begin
      way_q <= 1'b0;
    end else if (row.way_en) begin
      way_q <= hit ? hit_vec[1] : lru_way;
    end
  end

  // ------------------------------------------------------------
  // State register and transitions
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:          if (cachereq_val) state_d = ST_TAG_CHECK;
      ST_TAG_CHECK: begin
        if (is_init)      state_d = ST_INIT_ACCESS;
        else if (hit)     state_d = is_read ? ST_READ_ACCESS : ST_WRITE_ACCESS;
        else if (evict)   state_d = ST_EVICT_PREP;
        else if (refill)  state_d = ST_REFILL_REQ;
      end
      ST_READ_ACCESS,
      ST_WRITE_ACCESS,
      ST_INIT_ACCESS:   state_d = ST_WAIT;
      ST_REFILL_REQ:    if (memreq_rdy) state_d = ST_REFILL_WAIT;
      ST_REFILL_WAIT:   if (memresp_val) state_d = ST_REFILL_UPDATE;
      ST_REFILL_UPDATE: state_d = is_read ? ST_READ_ACCESS : ST_WRITE_ACCESS;
      ST_EVICT_PREP:    state_d = ST_EVICT_REQ;
      ST_EVICT_REQ:     if (memreq_rdy) state_d = ST_EVICT_WAIT;
      ST_EVICT_WAIT:    if (memresp_val) state_d = ST_REFILL_REQ;
      ST_WAIT:          if (cacheresp_rdy) state_d = ST_IDLE;
      default:          state_d = ST_IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // Control table
  // ------------------------------------------------------------

  // Columns: handshakes (req_rdy resp_val mreq_val mresp_rdy)
  //          dpath (req memresp refill tag data read evict)
  //          meta (vwen vval dwen dval lru) and way record
  always_comb begin
    case (state_q)
      ST_IDLE:          row = 17'b1000_1000000_00000_0;
      ST_TAG_CHECK:     row = 17'b0000_0000000_00000_1;
      ST_READ_ACCESS:   row = 17'b0000_0000010_00001_0;
      ST_WRITE_ACCESS:  row = 17'b0000_0000100_11111_0;
      ST_INIT_ACCESS:   row = 17'b0000_0001100_11101_0;
      ST_REFILL_REQ:    row = 17'b0010_0000000_00000_0;
      ST_REFILL_WAIT:   row = 17'b0001_0100000_00000_0;
      ST_REFILL_UPDATE: row = 17'b0000_0011100_11100_0;
      ST_EVICT_PREP:    row = 17'b0000_0000001_00000_0;
      ST_EVICT_REQ:     row = 17'b0010_0000000_00000_0;
      ST_EVICT_WAIT:    row = 17'b0001_0000000_00000_0;
      ST_WAIT:          row = 17'b0100_0000000_00000_0;
      default:          row = '0;
    endcase
  end

  assign cachereq_rdy  = row.req_rdy;
  assign cacheresp_val = row.resp_val;
  assign memreq_val    = row.mreq_val;
  assign memresp_rdy   = row.mresp_rdy;

  always_comb begin
    ctrl.req_en     = row.req_en;
    ctrl.memresp_en = row.mresp_en;
    ctrl.refill     = row.refill;
    ctrl.tag_wen    = row.tag_wen;
    ctrl.data_wen   = row.data_wen;
    ctrl.read_en    = row.read_en;
    ctrl.evict_en   = row.evict_en;
    ctrl.memreq_op  = (state_q == ST_EVICT_REQ) ? mem_msg_pkg::MEM_WRITE
                                                : mem_msg_pkg::MEM_READ;
    ctrl.way        = way_q;
  end

  always_comb begin
    meta_cmd.valid_wen = row.valid_wen;
    meta_cmd.valid_val = row.valid_val;
    meta_cmd.dirty_wen = row.dirty_wen;
    meta_cmd.dirty_val = row.dirty_val;
    meta_cmd.lru_wen   = row.lru_wen;
  end

endmodule

`default_nettype wire

// File: verilog/cache_dpath.sv
/* Cache datapath: request and refill registers, tag and data arrays.
   Arrays have no reset; the valid bits in the controller gate every hit. */
`default_nettype none
`timescale 1ns/1ns

module cache_dpath (
  input  logic                     clk,
  input  mem_msg_pkg::cache_req_t  cachereq,
  output mem_msg_pkg::cache_resp_t cacheresp,
  output mem_msg_pkg::mem_req_t    memreq,
  input  mem_msg_pkg::mem_resp_t   memresp,
  input  cache_pkg::dpath_ctrl_t   ctrl,
  output mem_msg_pkg::mem_op_e     req_op,
  output cache_pkg::cache_idx_t    req_idx,
  output logic [1:0]               tag_match
);

  mem_msg_pkg::cache_req_t              req_q;
  logic [mem_msg_pkg::LINE_BITS-1:0]    memresp_q;
  cache_pkg::cache_tag_t                req_tag;
  cache_pkg::word_sel_t                 word_sel;
  cache_pkg::cache_tag_t                tag_q [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
  logic [mem_msg_pkg::LINE_BITS-1:0]    data_q [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
  logic [mem_msg_pkg::LINE_BITS/8-1:0]  wben;
  logic [mem_msg_pkg::LINE_BITS-1:0]    wdata;
  logic [mem_msg_pkg::LINE_BITS-1:0]    line;
  logic [mem_msg_pkg::WORD_BITS-1:0]    read_q;
  logic [mem_msg_pkg::LINE_BITS-1:0]    evict_line_q;
  cache_pkg::cache_tag_t                evict_tag_q;

  // ------------------------------------------------------------
  // Input registers and address fields
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_q <= cachereq;
    end
    if (ctrl.memresp_en) begin
      memresp_q <= memresp.data;
    end
  end

  assign req_tag  = req_q.addr[mem_msg_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
  assign req_idx  = req_q.addr[cache_pkg::OFFSET_BITS +: cache_pkg::IDX_BITS];
  assign word_sel = req_q.addr[3:2];
  assign req_op   = req_q.op;

  // ------------------------------------------------------------
  // Tag and data arrays
  // ------------------------------------------------------------

  assign tag_match[0] = (tag_q[0][req_idx] == req_tag);
  assign tag_match[1] = (tag_q[1][req_idx] == req_tag);

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tag_q[ctrl.way][req_idx] <= req_tag;
    end
  end

  // Full line on refill, one word otherwise
  assign wben  = ctrl.refill ? '1 : (16'h000F << {word_sel, 2'b00});
  assign wdata = ctrl.refill ? memresp_q : {cache_pkg::WORDS_PER_LINE{req_q.data}};

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) begin
      for (int b = 0; b < mem_msg_pkg::LINE_BITS / 8; b++) begin
        if (wben[b]) begin
          data_q[ctrl.way][req_idx][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  assign line = data_q[ctrl.way][req_idx];

  // Read word and victim capture
  always_ff @(posedge clk) begin
    if (ctrl.read_en) begin
      read_q <= line[word_sel*mem_msg_pkg::WORD_BITS +: mem_msg_pkg::WORD_BITS];
    end
    if (ctrl.evict_en) begin
      evict_line_q <= line;
      evict_tag_q  <= tag_q[ctrl.way][req_idx];
    end
  end

  // ------------------------------------------------------------
  // Outgoing messages
  // ------------------------------------------------------------

  always_comb begin
    cacheresp.op     = req_q.op;
    cacheresp.opaque = req_q.opaque;
    cacheresp.data   = (req_q.op == mem_msg_pkg::MEM_READ) ? read_q : '0;
  end

  // Evict targets the victim line, refill the requested line
  always_comb begin
    memreq.op     = ctrl.memreq_op;
    memreq.opaque = '0;
    if (ctrl.memreq_op == mem_msg_pkg::MEM_WRITE) begin
      memreq.addr = {evict_tag_q, req_idx, {cache_pkg::OFFSET_BITS{1'b0}}};
      memreq.data = evict_line_q;
    end else begin
      memreq.addr = {req_tag, req_idx, {cache_pkg::OFFSET_BITS{1'b0}}};
      memreq.data = '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/blocking_cache.sv
/* Two-way write-back blocking cache; all four ports are valid/ready.
   Accepts a new request only after the previous response is taken. */
`default_nettype none
`timescale 1ns/1ns

module blocking_cache (
  input  logic                     clk,
  input  logic                     reset,
  input  mem_msg_pkg::cache_req_t  cachereq,
  input  logic                     cachereq_val,
  output logic                     cachereq_rdy,
  output mem_msg_pkg::cache_resp_t cacheresp,
  output logic                     cacheresp_val,
  input  logic                     cacheresp_rdy,
  output mem_msg_pkg::mem_req_t    memreq,
  output logic                     memreq_val,
  input  logic                     memreq_rdy,
  input  mem_msg_pkg::mem_resp_t   memresp,
  input  logic                     memresp_val,
  output logic                     memresp_rdy
);

  cache_pkg::dpath_ctrl_t ctrl;
  mem_msg_pkg::mem_op_e   req_op;
  cache_pkg::cache_idx_t  req_idx;
  logic [1:0]             tag_match;

  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .req_op        (req_op),
    .req_idx       (req_idx),
    .tag_match     (tag_match),
    .ctrl          (ctrl)
  );

  cache_dpath u_dpath (
    .clk       (clk),
    .cachereq  (cachereq),
    .cacheresp (cacheresp),
    .memreq    (memreq),
    .memresp   (memresp),
    .ctrl      (ctrl),
    .req_op    (req_op),
    .req_idx   (req_idx),
    .tag_match (tag_match)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
/* Free-running testbench clock with a 4 ns period, low at time zero */
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: dv/test_memory.sv
/* Line-wide memory model for the lower 16 KB of the address space only.
   One request at a time, random ready stalls, 0 to 3 cycles of response delay. */
`default_nettype none
`timescale 1ns/1ns

module test_memory (
  input  logic                   clk,
  input  logic                   reset,
  input  mem_msg_pkg::mem_req_t  memreq,
  input  logic                   memreq_val,
  output logic                   memreq_rdy,
  output mem_msg_pkg::mem_resp_t memresp,
  output logic                   memresp_val,
  input  logic                   memresp_rdy
);

  logic [mem_msg_pkg::LINE_BITS-1:0] lines [1024];
  mem_msg_pkg::mem_req_t             req_log [$];
  logic                              busy;
  int unsigned                       delay;

  // Initial content, a function of the full byte address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ a ^ 32'hC3A5_0F0F;
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++) begin
      for (int w = 0; w < 4; w++) begin
        lines[i][w*32 +: 32] = fill_word(i * 16 + w * 4);
      end
    end
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp     = '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      memreq_rdy  <= 1'b0;
      memresp_val <= 1'b0;
      memresp     <= '0;
      busy        <= 1'b0;
      delay       <= 0;
    end else if (!busy) begin
      if (memreq_val && memreq_rdy) begin
        req_log.push_back(memreq);
        memresp.op     <= memreq.op;
        memresp.opaque <= memreq.opaque;
        if (memreq.op == mem_msg_pkg::MEM_WRITE) begin
          lines[memreq.addr[13:4]] <= memreq.data;
          memresp.data             <= '0;
        end else begin
          memresp.data <= lines[memreq.addr[13:4]];
        end
        busy       <= 1'b1;
        memreq_rdy <= 1'b0;
        delay      <= $urandom_range(3, 0);
      end else begin
        // Ready about three cycles in four
        memreq_rdy <= ($urandom % 4) != 0;
      end
    end else if (!memresp_val) begin
      if (delay == 0) begin
        memresp_val <= 1'b1;
      end else begin
        delay <= delay - 1;
      end
    end else if (memresp_rdy) begin
      memresp_val <= 1'b0;
      busy        <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: dv/cache_props.sv
/* Handshake properties for the cache ports, bound into blocking_cache.
   Checks are disabled while reset is high. */
`default_nettype none
`timescale 1ns/1ns

module cache_props (
  input logic                     clk,
  input logic                     reset,
  input mem_msg_pkg::cache_req_t  cachereq,
  input logic                     cachereq_val,
  input logic                     cachereq_rdy,
  input mem_msg_pkg::cache_resp_t cacheresp,
  input logic                     cacheresp_val,
  input logic                     cacheresp_rdy,
  input mem_msg_pkg::mem_req_t    memreq,
  input logic                     memreq_val,
  input logic                     memreq_rdy,
  input mem_msg_pkg::mem_resp_t   memresp,
  input logic                     memresp_val,
  input logic                     memresp_rdy
);

  // Failure count, watched by the testbench
  int unsigned fails = 0;

  // ------------------------------------------------------------
  // Valid and payload held until the transfer
  // ------------------------------------------------------------

  cachereq_hold: assert property (@(posedge clk) disable iff (reset)
    cachereq_val && !cachereq_rdy |=> cachereq_val && $stable(cachereq))
    else begin
      fails++;
      $error("cachereq dropped or changed while stalled");
    end

  cacheresp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp))
    else begin
      fails++;
      $error("cacheresp dropped or changed while stalled");
    end

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq))
    else begin
      fails++;
      $error("memreq dropped or changed while stalled");
    end

  memresp_hold: assert property (@(posedge clk) disable iff (reset)
    memresp_val && !memresp_rdy |=> memresp_val && $stable(memresp))
    else begin
      fails++;
      $error("memresp dropped or changed while stalled");
    end

  // ------------------------------------------------------------
  // One request in flight, known request valid
  // ------------------------------------------------------------

  req_resp_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val))
    else begin
      fails++;
      $error("cachereq_rdy and cacheresp_val high together");
    end

  req_val_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(cachereq_val))
    else begin
      fails++;
      $error("cachereq_val is unknown");
    end

endmodule

bind blocking_cache cache_props u_props (
  .clk           (clk),
  .reset         (reset),
  .cachereq      (cachereq),
  .cachereq_val  (cachereq_val),
  .cachereq_rdy  (cachereq_rdy),
  .cacheresp     (cacheresp),
  .cacheresp_val (cacheresp_val),
  .cacheresp_rdy (cacheresp_rdy),
  .memreq        (memreq),
  .memreq_val    (memreq_val),
  .memreq_rdy    (memreq_rdy),
  .memresp       (memresp),
  .memresp_val   (memresp_val),
  .memresp_rdy   (memresp_rdy)
);

`default_nettype wire

// File: dv/cache_tb.sv
/* Directed tests for blocking_cache; all addresses stay below 16 KB.
   The line at 0xF20 holds write_init data and is not read after test 3. */
`default_nettype none
`timescale 1ns/1ns

module cache_tb;

  // About 60 transactions of at most 40 cycles each
  localparam int TIMEOUT_CYCLES = 4000;

  logic                     clk;
  logic                     reset;
  mem_msg_pkg::cache_req_t  cachereq;
  logic                     cachereq_val;
  logic                     cachereq_rdy;
  mem_msg_pkg::cache_resp_t cacheresp;
  logic                     cacheresp_val;
  logic                     cacheresp_rdy;
  mem_msg_pkg::mem_req_t    memreq;
  logic                     memreq_val;
  logic                     memreq_rdy;
  mem_msg_pkg::mem_resp_t   memresp;
  logic                     memresp_val;
  logic                     memresp_rdy;

  // Word image of memory as the requester sees it
  logic [31:0] model [4096];
  logic [7:0]  next_opaque;
  logic        resp_stall;
  int unsigned cycles;

  tb_clock u_clk (
    .clk (clk)
  );

  blocking_cache uut (
    .clk           (clk),
    .reset         (reset),
    .cachereq      (cachereq),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp     (cacheresp),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq        (memreq),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp       (memresp),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy)
  );

  test_memory u_mem (
    .clk         (clk),
    .reset       (reset),
    .memreq      (memreq),
    .memreq_val  (memreq_val),
    .memreq_rdy  (memreq_rdy),
    .memresp     (memresp),
    .memresp_val (memresp_val),
    .memresp_rdy (memresp_rdy)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ a ^ 32'hC3A5_0F0F;
  endfunction

  function automatic logic [127:0] model_line(input logic [31:0] addr);
    logic [11:0] base;
    base = {addr[13:4], 2'b00};
    return {model[base + 3], model[base + 2], model[base + 1], model[base]};
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
      else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_log_size(input string what, input int exp);
    assert (u_mem.req_log.size() == exp)
      else report_error($sformatf("%s: %0d memory requests, expected %0d",
                                  what, u_mem.req_log.size(), exp));
  endtask

  // One request and its response; lat counts edges from acceptance to valid
  task automatic access(input mem_msg_pkg::mem_op_e op, input logic [31:0] addr,
                        input logic [31:0] data, output int lat);
    mem_msg_pkg::cache_req_t  req;
    mem_msg_pkg::cache_resp_t resp;
    logic [31:0]              exp;
    req.op      = op;
    req.opaque  = next_opaque;
    req.addr    = addr;
    req.data    = data;
    next_opaque = next_opaque + 1;
    @(posedge clk);
    cachereq     <= req;
    cachereq_val <= 1'b1;
    @(negedge clk);
    while (!cachereq_rdy) begin
      @(negedge clk);
    end
    @(posedge clk);
    cachereq_val <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!cacheresp_val) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    while (!cacheresp_rdy) begin
      @(negedge clk);
    end
    resp = cacheresp;
    exp  = (op == mem_msg_pkg::MEM_READ) ? model[addr[13:2]] : 32'h0;
    if (op != mem_msg_pkg::MEM_READ) begin
      model[addr[13:2]] = data;
    end
    assert (resp.op == op)
      else report_error($sformatf("opcode not echoed for %h", addr));
    assert (resp.opaque == req.opaque)
      else report_error($sformatf("opaque %h not echoed, got %h", req.opaque, resp.opaque));
    check_word($sformatf("response data for %h", addr), resp.data, exp);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic test_read_miss();
    int n0;
    int lat;
    n0 = u_mem.req_log.size();
    access(mem_msg_pkg::MEM_READ, 32'h0000_0104, 32'h0, lat);
    check_log_size("read miss", n0 + 1);
    assert (u_mem.req_log[n0].op == mem_msg_pkg::MEM_READ)
      else report_error("refill request is not a read");
    check_word("refill address", u_mem.req_log[n0].addr, 32'h0000_0100);
  endtask

  task automatic test_read_hit();
    int n0;
    int lat;
    n0 = u_mem.req_log.size();
    access(mem_msg_pkg::MEM_READ, 32'h0000_0108, 32'h0, lat);
    check_log_size("read hit", n0);
    assert (lat == 3)
      else report_error($sformatf("hit latency %0d edges, expected 3", lat));
  endtask

  task automatic test_write_and_init();
    int n0;
    int lat;
    access(mem_msg_pkg::MEM_WRITE, 32'h0000_010C, 32'hDEAD_BEEF, lat);
    access(mem_msg_pkg::MEM_READ, 32'h0000_010C, 32'h0, lat);
    // Set 2 is clean, so no dirty data is lost here
    n0 = u_mem.req_log.size();
    access(mem_msg_pkg::MEM_WRITE_INIT, 32'h0000_0F28, 32'h1234_5678, lat);
    check_log_size("write_init", n0);
    access(mem_msg_pkg::MEM_READ, 32'h0000_0F28, 32'h0, lat);
    check_log_size("read after write_init", n0);
  endtask

  task automatic test_evict();
    int n0;
    int lat;
    logic [127:0] victim;
    access(mem_msg_pkg::MEM_WRITE, 32'h0000_0054, 32'hA0A0_0001, lat);
    access(mem_msg_pkg::MEM_WRITE, 32'h0000_0458, 32'hB0B0_0002, lat);
    victim = model_line(32'h0000_0050);
    n0 = u_mem.req_log.size();
    access(mem_msg_pkg::MEM_WRITE, 32'h0000_085C, 32'hC0C0_0003, lat);
    check_log_size("third tag in set 5", n0 + 2);
    assert (u_mem.req_log[n0].op == mem_msg_pkg::MEM_WRITE)
      else report_error("first request of the miss is not an evict");
    check_word("evict address", u_mem.req_log[n0].addr, 32'h0000_0050);
    assert (u_mem.req_log[n0].data === victim)
      else report_error($sformatf("evict data %h, expected %h",
                                  u_mem.req_log[n0].data, victim));
    assert (u_mem.req_log[n0 + 1].op == mem_msg_pkg::MEM_READ)
      else report_error("evict not followed by a refill read");
    check_word("refill address", u_mem.req_log[n0 + 1].addr, 32'h0000_0850);
    access(mem_msg_pkg::MEM_READ, 32'h0000_0054, 32'h0, lat);
  endtask

  task automatic test_random_traffic(input int count);
    int lat;
    logic [31:0] addr;
    mem_msg_pkg::mem_op_e op;
    @(posedge clk);
    resp_stall <= 1'b1;
    for (int i = 0; i < count; i++) begin
      // 4 KB window at 0x1000, 32 tags per set
      addr = 32'h0000_1000 + (($urandom % 1024) << 2);
      op   = ($urandom % 2) ? mem_msg_pkg::MEM_WRITE : mem_msg_pkg::MEM_READ;
      access(op, addr, $urandom, lat);
    end
    @(posedge clk);
    resp_stall <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // Response back-pressure, timeout and bound checks
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (reset || !resp_stall) begin
      cacheresp_rdy <= 1'b1;
    end else begin
      cacheresp_rdy <= ($urandom % 3) == 0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "Simulation timed out");
    end else if (uut.u_props.fails != 0) begin
      $display("A bound handshake assertion failed");
      $display("Finished with errors");
      $fatal(1, "Bound handshake assertions failed");
    end
  end

  initial begin
    void'($urandom(11712));
    reset         = 1'b1;
    cachereq      = '0;
    cachereq_val  = 1'b0;
    cacheresp_rdy = 1'b1;
    resp_stall    = 1'b0;
    next_opaque   = 8'h10;
    cycles        = 0;
    for (int i = 0; i < 4096; i++) begin
      model[i] = fill_word(i * 4);
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    test_read_miss();
    test_read_hit();
    test_write_and_init();
    test_evict();
    test_random_traffic(40);

    repeat (4) @(posedge clk);
    if (uut.u_props.fails == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Bound handshake assertions failed");
    end
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/mem_msg_pkg.sv
verilog/cache_pkg.sv
verilog/cache_meta.sv
verilog/cache_ctrl.sv
verilog/cache_dpath.sv
verilog/blocking_cache.sv
dv/tb_clock.sv
dv/test_memory.sv
dv/cache_props.sv
dv/cache_tb.sv

// File: Bender.yml
package:
  name: blocking_cache

sources:
  - files:
      - verilog/mem_msg_pkg.sv
      - verilog/cache_pkg.sv
      - verilog/cache_meta.sv
      - verilog/cache_ctrl.sv
      - verilog/cache_dpath.sv
      - verilog/blocking_cache.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/test_memory.sv
      - dv/cache_props.sv
      - dv/cache_tb.sv
